// ==== rtl/axi_perf_pkg.sv ====
package axi_perf_pkg;

  localparam int addr_width      = 8;  // byte address.
  localparam int data_width      = 16;
  localparam int strb_width      = data_width / 8;
  localparam int id_width        = 4;
  localparam int stat_width      = 32;
  localparam int mem_words       = (2 ** addr_width) / strb_width;
  localparam int word_addr_width = $clog2(mem_words);

  localparam logic [2:0] beat_size  = 3'($clog2(strb_width));  // full width beats.
  localparam logic [1:0] burst_incr = 2'd1;
  localparam logic [1:0] resp_okay  = 2'd0;

  localparam logic [addr_width-1:0] beat_bytes = addr_width'(strb_width);
  localparam logic [id_width-1:0]   wr_id      = 4'h1;
  localparam logic [id_width-1:0]   rd_id      = 4'h2;

  // shared by aw and ar.
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [id_width-1:0]   id;
    logic [7:0]            len;
    logic [2:0]            size;
    logic [1:0]            burst;
  } axi_aw_t;

  typedef struct packed {
    logic [data_width-1:0] data;
    logic [strb_width-1:0] strb;
    logic                  last;
  } axi_w_t;

  typedef struct packed {
    logic [id_width-1:0] id;
    logic [1:0]          resp;
  } axi_b_t;

  typedef struct packed {
    logic [id_width-1:0]   id;
    logic [data_width-1:0] data;
    logic [1:0]            resp;
    logic                  last;
  } axi_r_t;

  typedef enum logic [1:0] {
    op_write      = 2'd0,
    op_read       = 2'd1,
    op_write_read = 2'd2
  } perf_op_e;

  typedef struct packed {
    perf_op_e              op;
    logic [addr_width-1:0] base;
    logic [7:0]            len;    // axi length field.
    logic [7:0]            count;  // bursts per phase.
    logic [15:0]           seed;
  } perf_cmd_t;

  typedef struct packed {
    logic [stat_width-1:0] cycles;
    logic [stat_width-1:0] wr_beats;
    logic [stat_width-1:0] rd_beats;
    logic [stat_width-1:0] aw_stalls;
    logic [stat_width-1:0] ar_stalls;
    logic [stat_width-1:0] errors;
  } perf_stats_t;

endpackage

// ==== rtl/axi_mem.sv ====
`timescale 1ns/1ps

module axi_mem (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  axi_perf_pkg::axi_aw_t aw,
  input  logic                  w_valid,
  output logic                  w_ready,
  input  axi_perf_pkg::axi_w_t  w,
  output logic                  b_valid,
  input  logic                  b_ready,
  output axi_perf_pkg::axi_b_t  b,
  input  logic                  ar_valid,
  output logic                  ar_ready,
  input  axi_perf_pkg::axi_aw_t ar,
  output logic                  r_valid,
  input  logic                  r_ready,
  output axi_perf_pkg::axi_r_t  r
);
  localparam int aw_hi = axi_perf_pkg::addr_width - 1;
  localparam int aw_lo = axi_perf_pkg::addr_width - axi_perf_pkg::word_addr_width;

  typedef enum logic [1:0] {
    wr_idle,
    wr_data,
    wr_resp
  } wr_state_e;

  typedef enum logic {
    rd_idle,
    rd_data
  } rd_state_e;

  wr_state_e                                wr_state;
  rd_state_e                                rd_state;
  logic [axi_perf_pkg::data_width-1:0]      mem [axi_perf_pkg::mem_words];
  logic [axi_perf_pkg::word_addr_width-1:0] wr_addr;
  logic [axi_perf_pkg::word_addr_width-1:0] rd_addr;
  logic [axi_perf_pkg::word_addr_width-1:0] rd_next;
  logic [axi_perf_pkg::id_width-1:0]        bid_q;
  logic [axi_perf_pkg::id_width-1:0]        rid_q;
  logic [7:0]                               rd_left;
  logic [axi_perf_pkg::data_width-1:0]      rd_word;
  logic                                     aw_fire;
  logic                                     w_fire;
  logic                                     ar_fire;
  logic                                     r_fire;

  assign aw_ready = wr_state == wr_idle;
  assign w_ready  = wr_state == wr_data;
  assign b_valid  = wr_state == wr_resp;
  assign aw_fire  = aw_valid && aw_ready;
  assign w_fire   = w_valid && w_ready;

  assign b.id   = bid_q;
  assign b.resp = axi_perf_pkg::resp_okay;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_state <= wr_idle;
    end else begin
      case (wr_state)
        wr_idle: if (aw_valid) wr_state <= wr_data;
        wr_data: if (w_valid && w.last) wr_state <= wr_resp;
        wr_resp: if (b_ready) wr_state <= wr_idle;
        default: wr_state <= wr_idle;
      endcase
    end
  end

  // word address wraps at the top of the array.
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      wr_addr <= aw.addr[aw_hi:aw_lo];
      bid_q   <= aw.id;
    end else if (w_fire) begin
      wr_addr <= wr_addr + 1;
    end
  end

  always_ff @(posedge clk) begin
    if (w_fire) begin
      for (int i = 0; i < axi_perf_pkg::strb_width; i++) begin
        if (w.strb[i]) begin
          mem[wr_addr][i*8 +: 8] <= w.data[i*8 +: 8];
        end
      end
    end
  end

  assign ar_ready = rd_state == rd_idle;
  assign r_valid  = rd_state == rd_data;
  assign ar_fire  = ar_valid && ar_ready;
  assign r_fire   = r_valid && r_ready;
  assign rd_next  = ar_fire ? ar.addr[aw_hi:aw_lo] : rd_addr + 1;

  assign r.id   = rid_q;
  assign r.data = rd_word;
  assign r.resp = axi_perf_pkg::resp_okay;
  assign r.last = rd_left == 8'd0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_state <= rd_idle;
    end else begin
      case (rd_state)
        rd_idle: if (ar_valid) rd_state <= rd_data;
        rd_data: if (r_ready && r.last) rd_state <= rd_idle;
        default: rd_state <= rd_idle;
      endcase
    end
  end

  // prefetch the next word so each beat is held while rready is low.
  always_ff @(posedge clk) begin
    if (ar_fire || r_fire) begin
      rd_addr <= rd_next;
      rd_word <= mem[rd_next];
    end
    if (ar_fire) begin
      rid_q   <= ar.id;
      rd_left <= ar.len;
    end else if (r_fire) begin
      rd_left <= rd_left - 8'd1;
    end
  end

endmodule

// ==== rtl/axi_perf_ctrl.sv ====
`timescale 1ns/1ps

module axi_perf_ctrl (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    cmd_valid,
  output logic                    cmd_ready,
  input  axi_perf_pkg::perf_cmd_t cmd,
  output logic                    stats_valid,
  input  logic                    stats_ready,
  output logic                    wr_start,
  output logic                    rd_start,
  output axi_perf_pkg::perf_cmd_t start_cmd,
  input  logic                    wr_done,
  input  logic                    rd_done,
  output logic                    run_clear,
  output logic                    run_busy
);
  typedef enum logic [2:0] {
    st_idle,
    st_clear,
    st_write,
    st_read,
    st_report
  } state_e;

  state_e                  state;
  axi_perf_pkg::perf_cmd_t cmd_q;

  assign cmd_ready   = state == st_idle;
  assign run_clear   = state == st_clear;
  assign run_busy    = (state == st_write) || (state == st_read);
  assign stats_valid = state == st_report;  // counters are frozen here.
  assign start_cmd   = cmd_q;

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      cmd_q <= cmd;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= st_idle;
      wr_start <= 1'b0;
      rd_start <= 1'b0;
    end else begin
      wr_start <= 1'b0;
      rd_start <= 1'b0;
      case (state)
        st_idle: begin
          if (cmd_valid) begin
            state <= st_clear;
          end
        end
        st_clear: begin
          if (cmd_q.op == axi_perf_pkg::op_read) begin
            state    <= st_read;
            rd_start <= 1'b1;
          end else begin
            state    <= st_write;
            wr_start <= 1'b1;
          end
        end
        st_write: begin
          if (wr_done && cmd_q.op == axi_perf_pkg::op_write_read) begin
            state    <= st_read;
            rd_start <= 1'b1;
          end else if (wr_done) begin
            state <= st_report;
          end
        end
        st_read: begin
          if (rd_done) begin
            state <= st_report;
          end
        end
        st_report: begin
          if (stats_ready) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== rtl/axi_perf_wgen.sv ====
`timescale 1ns/1ps

module axi_perf_wgen (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  axi_perf_pkg::perf_cmd_t start_cmd,
  output logic                    done,
  output logic                    aw_valid,
  input  logic                    aw_ready,
  output axi_perf_pkg::axi_aw_t   aw,
  output logic                    w_valid,
  input  logic                    w_ready,
  output axi_perf_pkg::axi_w_t    w,
  input  logic                    b_valid,
  output logic                    b_ready,
  input  axi_perf_pkg::axi_b_t    b
);
  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data,
    st_resp
  } state_e;

  state_e                              state;
  logic [7:0]                          bursts_left;
  logic [7:0]                          beat;
  logic [axi_perf_pkg::addr_width-1:0] addr;
  logic [7:0]                          len;
  logic [axi_perf_pkg::data_width-1:0] seed;
  logic [axi_perf_pkg::data_width-1:0] idx;  // beat index across the run.
  logic                                w_fire;
  logic                                b_fire;

  assign aw_valid = state == st_addr;
  assign w_valid  = state == st_data;
  assign b_ready  = 1'b1;
  assign w_fire   = w_valid && w_ready;
  assign b_fire   = b_valid && b_ready && (b.id == axi_perf_pkg::wr_id);

  assign aw.addr  = addr;
  assign aw.id    = axi_perf_pkg::wr_id;
  assign aw.len   = len;
  assign aw.size  = axi_perf_pkg::beat_size;
  assign aw.burst = axi_perf_pkg::burst_incr;

  assign w.data = seed + idx;
  assign w.strb = '1;
  assign w.last = beat == len;

  // address walks one beat per w transfer, so the next aw starts right after.
  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      addr <= start_cmd.base;
      len  <= start_cmd.len;
      seed <= start_cmd.seed;
      idx  <= '0;
    end else if (w_fire) begin
      addr <= addr + axi_perf_pkg::beat_bytes;
      idx  <= idx + 1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= st_idle;
      bursts_left <= 8'd0;
      beat        <= 8'd0;
      done        <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state       <= st_addr;
            bursts_left <= start_cmd.count;
          end
        end
        st_addr: begin
          if (aw_ready) begin
            state <= st_data;
            beat  <= 8'd0;
          end
        end
        st_data: begin
          if (w_fire) begin
            beat <= beat + 8'd1;
            if (w.last) begin
              state <= st_resp;
            end
          end
        end
        st_resp: begin
          if (b_fire && bursts_left <= 8'd1) begin
            state <= st_idle;
            done  <= 1'b1;
          end else if (b_fire) begin
            state       <= st_addr;
            bursts_left <= bursts_left - 8'd1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== rtl/axi_perf_rchk.sv ====
`timescale 1ns/1ps

module axi_perf_rchk (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    start,
  input  axi_perf_pkg::perf_cmd_t start_cmd,
  output logic                    done,
  output logic                    ar_valid,
  input  logic                    ar_ready,
  output axi_perf_pkg::axi_aw_t   ar,
  input  logic                    r_valid,
  output logic                    r_ready,
  input  axi_perf_pkg::axi_r_t    r,
  output logic                    beat_err
);
  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data
  } state_e;

  state_e                              state;
  logic [7:0]                          bursts_left;
  logic [axi_perf_pkg::addr_width-1:0] addr;
  logic [7:0]                          len;
  logic [axi_perf_pkg::data_width-1:0] seed;
  logic [axi_perf_pkg::data_width-1:0] idx;
  logic [axi_perf_pkg::data_width-1:0] expected;
  logic                                r_fire;

  assign ar_valid = state == st_addr;
  assign r_ready  = 1'b1;
  assign r_fire   = r_valid && r_ready && (state == st_data);

  assign ar.addr  = addr;
  assign ar.id    = axi_perf_pkg::rd_id;
  assign ar.len   = len;
  assign ar.size  = axi_perf_pkg::beat_size;
  assign ar.burst = axi_perf_pkg::burst_incr;

  assign expected = seed + idx;  // same pattern the write side produced.
  assign beat_err = r_fire && (r.data != expected);

  always_ff @(posedge clk) begin
    if (state == st_idle && start) begin
      addr <= start_cmd.base;
      len  <= start_cmd.len;
      seed <= start_cmd.seed;
      idx  <= '0;
    end else if (r_fire) begin
      addr <= addr + axi_perf_pkg::beat_bytes;
      idx  <= idx + 1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= st_idle;
      bursts_left <= 8'd0;
      done        <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state       <= st_addr;
            bursts_left <= start_cmd.count;
          end
        end
        st_addr: begin
          if (ar_ready) begin
            state <= st_data;
          end
        end
        st_data: begin
          if (r_fire && r.last && bursts_left <= 8'd1) begin
            state <= st_idle;
            done  <= 1'b1;
          end else if (r_fire && r.last) begin
            state       <= st_addr;
            bursts_left <= bursts_left - 8'd1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

endmodule

// ==== rtl/axi_perf_stats.sv ====
`timescale 1ns/1ps

module axi_perf_stats (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      run_clear,
  input  logic                      run_busy,
  input  logic                      aw_valid,
  input  logic                      aw_ready,
  input  logic                      ar_valid,
  input  logic                      ar_ready,
  input  logic                      w_fire,
  input  logic                      r_fire,
  input  logic                      beat_err,
  output axi_perf_pkg::perf_stats_t stats
);
  typedef logic [axi_perf_pkg::stat_width-1:0] count_t;

  // holds at all ones instead of wrapping.
  function automatic count_t bump(input count_t value, input logic en);
    if (en && value != '1) begin
      return value + 1;
    end
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n || run_clear) begin
      stats <= '0;
    end else if (run_busy) begin
      stats.cycles    <= bump(stats.cycles, 1'b1);
      stats.wr_beats  <= bump(stats.wr_beats, w_fire);
      stats.rd_beats  <= bump(stats.rd_beats, r_fire);
      stats.aw_stalls <= bump(stats.aw_stalls, aw_valid && !aw_ready);
      stats.ar_stalls <= bump(stats.ar_stalls, ar_valid && !ar_ready);
      stats.errors    <= bump(stats.errors, beat_err);
    end
  end

endmodule

// ==== rtl/axi_perf_mem.sv ====
`timescale 1ns/1ps

module axi_perf_mem (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      cmd_valid,
  output logic                      cmd_ready,
  input  axi_perf_pkg::perf_cmd_t   cmd,
  output logic                      stats_valid,
  input  logic                      stats_ready,
  output axi_perf_pkg::perf_stats_t stats
);
  logic                    aw_valid;
  logic                    aw_ready;
  axi_perf_pkg::axi_aw_t   aw;
  logic                    w_valid;
  logic                    w_ready;
  axi_perf_pkg::axi_w_t    w;
  logic                    b_valid;
  logic                    b_ready;
  axi_perf_pkg::axi_b_t    b;
  logic                    ar_valid;
  logic                    ar_ready;
  axi_perf_pkg::axi_aw_t   ar;
  logic                    r_valid;
  logic                    r_ready;
  axi_perf_pkg::axi_r_t    r;
  logic                    wr_start;
  logic                    rd_start;
  axi_perf_pkg::perf_cmd_t start_cmd;
  logic                    wr_done;
  logic                    rd_done;
  logic                    run_clear;
  logic                    run_busy;
  logic                    beat_err;

  axi_perf_ctrl axi_perf_ctrl_i (.*);

  axi_perf_wgen axi_perf_wgen_i (
    .*,
    .start(wr_start),
    .done (wr_done)
  );

  axi_perf_rchk axi_perf_rchk_i (
    .*,
    .start(rd_start),
    .done (rd_done)
  );

  axi_perf_stats axi_perf_stats_i (
    .*,
    .w_fire(w_valid && w_ready),
    .r_fire(r_valid && r_ready)
  );

  axi_mem axi_mem_i (.*);

endmodule

// ==== tests/axi_perf_mem_props.sv ====
`timescale 1ns/1ps

module axi_perf_mem_props (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  aw_valid,
  input logic                  aw_ready,
  input axi_perf_pkg::axi_aw_t aw,
  input logic                  w_valid,
  input logic                  w_ready,
  input axi_perf_pkg::axi_w_t  w,
  input logic                  b_valid,
  input logic                  b_ready,
  input logic                  r_valid,
  input logic                  r_ready,
  input axi_perf_pkg::axi_r_t  r
);
  logic wlast_pending;  // wlast taken, b not yet taken.

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wlast_pending <= 1'b0;
    end else if (w_valid && w_ready && w.last) begin
      wlast_pending <= 1'b1;
    end else if (b_valid && b_ready) begin
      wlast_pending <= 1'b0;
    end
  end

  aw_held: assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw))
    else $error("aw valid or payload changed before aw ready");

  w_held: assert property (@(posedge clk) disable iff (!rst_n)
    w_valid && !w_ready |=> w_valid && $stable(w))
    else $error("w valid or payload changed before w ready");

  r_held: assert property (@(posedge clk) disable iff (!rst_n)
    r_valid && !r_ready |=> r_valid && $stable(r))
    else $error("r valid or payload changed before r ready");

  b_after_wlast: assert property (@(posedge clk) disable iff (!rst_n)
    b_valid |-> wlast_pending)
    else $error("b valid without a preceding wlast transfer");

endmodule

bind axi_mem axi_perf_mem_props axi_perf_mem_props_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .aw_valid(aw_valid),
  .aw_ready(aw_ready),
  .aw      (aw),
  .w_valid (w_valid),
  .w_ready (w_ready),
  .w       (w),
  .b_valid (b_valid),
  .b_ready (b_ready),
  .r_valid (r_valid),
  .r_ready (r_ready),
  .r       (r)
);

// ==== tests/axi_perf_mem_tb.sv ====
`timescale 1ns/1ps

module axi_perf_mem_tb;
  localparam int num_random     = 24;
  localparam int num_cmds       = num_random + 3;
  localparam int cycles_per_cmd = 2000;

  logic                      clk;
  logic                      rst_n;
  logic                      cmd_valid;
  logic                      cmd_ready;
  axi_perf_pkg::perf_cmd_t   cmd;
  logic                      stats_valid;
  logic                      stats_ready;
  axi_perf_pkg::perf_stats_t stats;

  logic [axi_perf_pkg::data_width-1:0] model_mem [axi_perf_pkg::mem_words];
  bit                                  model_known [axi_perf_pkg::mem_words];
  int                                  n_tests;
  int                                  n_failed;
  int                                  n_errors;

  axi_perf_mem axi_perf_mem_i (.*);

  always #4 clk = ~clk;

  function automatic int beats_of(input axi_perf_pkg::perf_cmd_t c);
    return (int'(c.len) + 1) * int'(c.count);
  endfunction

  // the low address bit falls away on a two byte bus.
  function automatic int word_of(input axi_perf_pkg::perf_cmd_t c, input int i);
    return (int'(c.base) / 2 + i) % axi_perf_pkg::mem_words;
  endfunction

  function automatic void model_write(input axi_perf_pkg::perf_cmd_t c);
    int word;
    for (int i = 0; i < beats_of(c); i++) begin
      word = word_of(c, i);
      model_mem[word]   = c.seed + 16'(i);
      model_known[word] = 1'b1;
    end
  endfunction

  function automatic int model_mismatches(input axi_perf_pkg::perf_cmd_t c);
    int count;
    int word;
    count = 0;
    for (int i = 0; i < beats_of(c); i++) begin
      word = word_of(c, i);
      if (!model_known[word] || model_mem[word] != c.seed + 16'(i)) begin
        count++;
      end
    end
    return count;
  endfunction

  function automatic string op_name(input axi_perf_pkg::perf_op_e op);
    case (op)
      axi_perf_pkg::op_write:      return "write";
      axi_perf_pkg::op_read:       return "read";
      axi_perf_pkg::op_write_read: return "write_read";
      default:                     return "unknown";
    endcase
  endfunction

  function automatic axi_perf_pkg::perf_cmd_t make_cmd(input axi_perf_pkg::perf_op_e op,
                                                       input logic [7:0] base,
                                                       input logic [7:0] len,
                                                       input logic [7:0] count,
                                                       input logic [15:0] seed);
    axi_perf_pkg::perf_cmd_t c;
    c.op    = op;
    c.base  = base;
    c.len   = len;
    c.count = count;
    c.seed  = seed;
    return c;
  endfunction

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    n_errors++;
  endtask

  task automatic send_command(input axi_perf_pkg::perf_cmd_t c);
    cmd_valid <= 1'b1;
    cmd       <= c;
    do begin
      @(posedge clk);
    end while (!cmd_ready);
    cmd_valid <= 1'b0;
  endtask

  // stats_ready stays low for a random stretch while the snapshot is watched.
  task automatic collect_stats(output axi_perf_pkg::perf_stats_t snap);
    int hold;
    do begin
      @(posedge clk);
    end while (!stats_valid);
    snap = stats;
    hold = $urandom_range(6, 0);
    repeat (hold) begin
      @(posedge clk);
      if (!stats_valid) begin
        $display("stats_valid dropped at %0t while stats_ready was low", $time);
        n_errors++;
      end
      if (stats != snap) begin
        $display("mismatch at %0t: stats changed while stats_ready was low", $time);
        n_errors++;
      end
      if (cmd_ready) begin
        $display("cmd_ready rose at %0t before the stats transfer", $time);
        n_errors++;
      end
    end
    stats_ready <= 1'b1;
    @(posedge clk);
    if (!stats_valid) begin
      $display("stats_valid was low at %0t on the stats transfer", $time);
      n_errors++;
    end
    stats_ready <= 1'b0;
  endtask

  task automatic run_test(input string name, input axi_perf_pkg::perf_cmd_t c);
    axi_perf_pkg::perf_stats_t s;
    logic [31:0]               wr_exp;
    logic [31:0]               rd_exp;
    logic [31:0]               err_exp;
    int                        errors_before;
    errors_before = n_errors;
    wr_exp        = '0;
    rd_exp        = '0;
    err_exp       = '0;
    if (c.op != axi_perf_pkg::op_read) begin
      wr_exp = 32'(beats_of(c));
      model_write(c);  // reads of a write_read run see this data.
    end
    if (c.op != axi_perf_pkg::op_write) begin
      rd_exp  = 32'(beats_of(c));
      err_exp = 32'(model_mismatches(c));
    end
    repeat ($urandom_range(3, 0)) @(posedge clk);
    send_command(c);
    collect_stats(s);
    if (s.wr_beats != wr_exp) report_mismatch("write beats", s.wr_beats, wr_exp);
    if (s.rd_beats != rd_exp) report_mismatch("read beats", s.rd_beats, rd_exp);
    if (s.errors != err_exp) report_mismatch("data errors", s.errors, err_exp);
    if (c.op == axi_perf_pkg::op_write && s.ar_stalls != 0) begin
      report_mismatch("ar stalls", s.ar_stalls, 32'd0);
    end
    if (c.op == axi_perf_pkg::op_read && s.aw_stalls != 0) begin
      report_mismatch("aw stalls", s.aw_stalls, 32'd0);
    end
    if (s.cycles == 0) begin
      $display("cycle count was zero at %0t for a finished run", $time);
      n_errors++;
    end
    if (s.cycles < wr_exp + rd_exp) begin
      report_mismatch("cycles against beat total", s.cycles, wr_exp + rd_exp);
    end
    n_tests++;
    if (n_errors != errors_before) begin
      n_failed++;
    end
    $display("test %0d %s op %s base %0d len %0d count %0d: %s", n_tests, name,
             op_name(c.op), c.base, c.len, c.count,
             (n_errors == errors_before) ? "ok" : "failed");
  endtask

  initial begin
    axi_perf_pkg::perf_cmd_t c;
    logic [15:0]             seed;
    void'($urandom(32'hae93));
    clk         = 1'b0;
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd         = '0;
    stats_ready = 1'b0;
    n_tests     = 0;
    n_failed    = 0;
    n_errors    = 0;
    for (int i = 0; i < axi_perf_pkg::mem_words; i++) begin
      model_known[i] = 1'b0;
    end
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (!cmd_ready) report_mismatch("cmd_ready after reset", 32'(cmd_ready), 32'd1);
    if (stats_valid) report_mismatch("stats_valid after reset", 32'(stats_valid), 32'd0);
    $display("test 0 reset state: %s", (n_errors == 0) ? "ok" : "failed");
    if (n_errors != 0) begin
      n_failed++;
    end

    // fill the whole array so every word has a known value.
    c = make_cmd(axi_perf_pkg::op_write, 8'd0, 8'd7, 8'd16, 16'($urandom()));
    run_test("fill", c);
    seed = 16'($urandom());
    c    = make_cmd(axi_perf_pkg::op_write, 8'($urandom()), 8'd3, 8'd4, seed);
    run_test("write only", c);
    c.op   = axi_perf_pkg::op_read;
    c.seed = seed + 16'd1;  // every beat should miss.
    run_test("read other seed", c);

    for (int i = 0; i < num_random; i++) begin
      c = make_cmd(axi_perf_pkg::perf_op_e'(2'($urandom_range(2, 0))),
                   8'($urandom()), 8'($urandom_range(7, 0)), 8'($urandom_range(6, 1)),
                   16'($urandom()));
      run_test("random", c);
    end

    $display("%0d tests, %0d failed, %0d errors", n_tests + 1, n_failed, n_errors);
    if (n_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  initial begin
    repeat (cycles_per_cmd * num_cmds) @(posedge clk);
    $display("timeout: the runs did not finish within %0d cycles",
             cycles_per_cmd * num_cmds);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== axi_perf_mem.f ====
rtl/axi_perf_pkg.sv
rtl/axi_mem.sv
rtl/axi_perf_ctrl.sv
rtl/axi_perf_wgen.sv
rtl/axi_perf_rchk.sv
rtl/axi_perf_stats.sv
rtl/axi_perf_mem.sv
tests/axi_perf_mem_props.sv
tests/axi_perf_mem_tb.sv

// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module axi_perf_mem_tb \
	  -f axi_perf_mem.f -Mdir obj_dir -o axi_perf_mem_sim

run: compile
	./obj_dir/axi_perf_mem_sim > sim.log 2>&1; cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
